/* design/sa_pkg.sv */
`default_nettype none

package sa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Array geometry
    //////////////////////////////////////////////////////////////////////
    localparam int sa_dim      = 4;                  // Rows, cols and inner dim
    localparam int elem_n      = sa_dim * sa_dim;
    localparam int idx_w       = $clog2(sa_dim);
    localparam int elem_w      = $clog2(elem_n);     // Element index in a window

    // Inner dim plus the skew on both edges of the grid
    localparam int feed_cycles = sa_dim + 2 * sa_dim - 2;
    localparam int step_w      = $clog2(feed_cycles + 1);

    //////////////////////////////////////////////////////////////////////
    // Q2.13 data path
    //////////////////////////////////////////////////////////////////////
    localparam int data_w  = 16;
    localparam int frac_w  = 13;                     // Product scaling shift
    localparam int acc_w   = 32;                     // Wrapping accumulator
    localparam int sat_max = (1 << (data_w - 1)) - 1;
    localparam int sat_min = -(1 << (data_w - 1));

    //////////////////////////////////////////////////////////////////////
    // APB map
    //////////////////////////////////////////////////////////////////////
    localparam int addr_w  = 8;
    localparam int pdata_w = 32;
    localparam int win_lsb = elem_w + 2;             // One element per word

    localparam logic [addr_w-1:0] reg_ctrl   = 8'h00;  // Bit 0 starts a run
    localparam logic [addr_w-1:0] reg_status = 8'h04;  // Bit 0 busy, bit 1 done
    localparam logic [addr_w-1:0] win_x      = 8'h40;
    localparam logic [addr_w-1:0] win_w      = 8'h80;
    localparam logic [addr_w-1:0] win_out    = 8'hC0;

endpackage

`default_nettype wire

/* design/sa_apb_regs.sv */
`default_nettype none

module sa_apb_regs (
    input  logic                                    I_CLK,
    input  logic                                    I_ASYN_RSTN,
    // APB slave
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [sa_pkg::addr_w-1:0]               paddr,
    input  logic [sa_pkg::pdata_w-1:0]              pwdata,
    output logic [sa_pkg::pdata_w-1:0]              prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    // Feeder and array side
    input  logic                                    busy,
    input  logic                                    done,
    input  logic [sa_pkg::elem_n*sa_pkg::data_w-1:0] result_bus,
    output logic                                    start,
    input  logic [sa_pkg::idx_w-1:0]                x_rd_row,
    input  logic [sa_pkg::idx_w-1:0]                w_rd_col,
    output logic [sa_pkg::sa_dim*sa_pkg::data_w-1:0] x_rd_data,
    output logic [sa_pkg::sa_dim*sa_pkg::data_w-1:0] w_rd_data
);
    import sa_pkg::*;

    logic [data_w-1:0]  x_mem [elem_n];  // Row-major X
    logic [data_w-1:0]  w_mem [elem_n];  // Row-major W
    logic               done_q;

    logic               access;
    logic               aligned;
    logic               hit_ctrl;
    logic               hit_status;
    logic               hit_x;
    logic               hit_w;
    logic               hit_out;
    logic               locked;
    logic               err;
    logic               wr_ok;
    logic [elem_w-1:0]  elem;
    logic [pdata_w-1:0] status_word;

    function automatic logic [pdata_w-1:0] sext(input logic [data_w-1:0] v);
        return {{(pdata_w - data_w){v[data_w-1]}}, v};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////
    assign access     = psel & penable;  // Zero wait states, completes here
    assign aligned    = (paddr[1:0] == 2'b00);
    assign elem       = paddr[win_lsb-1:2];
    assign hit_ctrl   = (paddr == reg_ctrl);
    assign hit_status = (paddr == reg_status);
    assign hit_x      = aligned & (paddr[addr_w-1:win_lsb] == win_x[addr_w-1:win_lsb]);
    assign hit_w      = aligned & (paddr[addr_w-1:win_lsb] == win_w[addr_w-1:win_lsb]);
    assign hit_out    = aligned & (paddr[addr_w-1:win_lsb] == win_out[addr_w-1:win_lsb]);

    // Operands and ctrl are frozen from the start pulse until the run ends
    assign locked = busy | start;

    always_comb begin
        err = 1'b0;
        if (!(hit_ctrl | hit_status | hit_x | hit_w | hit_out)) begin
            err = 1'b1;                   // Unmapped
        end else if (pwrite && hit_out) begin
            err = 1'b1;                   // Results are read only
        end else if (pwrite && locked && (hit_ctrl | hit_x | hit_w)) begin
            err = 1'b1;
        end
    end

    assign pready  = 1'b1;
    assign pslverr = access & err;
    assign wr_ok   = access & pwrite & ~err;

    //////////////////////////////////////////////////////////////////////
    // Operand buffers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge I_CLK) begin
        if (wr_ok && hit_x) begin
            x_mem[elem] <= pwdata[data_w-1:0];
        end
        if (wr_ok && hit_w) begin
            w_mem[elem] <= pwdata[data_w-1:0];
        end
    end

    // Step read for the feeder: element x_rd_row of every X row,
    // and element w_rd_col of every W column
    for (genvar r = 0; r < sa_dim; r++) begin : g_rd
        assign x_rd_data[r*data_w +: data_w] = x_mem[{idx_w'(r), x_rd_row}];
        assign w_rd_data[r*data_w +: data_w] = w_mem[{w_rd_col, idx_w'(r)}];
    end

    //////////////////////////////////////////////////////////////////////
    // Control and status
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            start  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            start <= wr_ok & hit_ctrl & pwdata[0];
            if (start) begin
                done_q <= 1'b0;           // Next run clears sticky done
            end else if (done) begin
                done_q <= 1'b1;
            end
        end
    end

    // Done shows in the same cycle as the feeder pulse
    assign status_word = {{(pdata_w - 2){1'b0}}, done_q | done, busy};

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_status) begin
                prdata = status_word;
            end else if (hit_x) begin
                prdata = sext(x_mem[elem]);
            end else if (hit_w) begin
                prdata = sext(w_mem[elem]);
            end else if (hit_out) begin
                prdata = sext(result_bus[elem*data_w +: data_w]);
            end
        end
    end

endmodule

`default_nettype wire

/* design/sa_operand_feeder.sv */
`default_nettype none

module sa_operand_feeder (
    input  logic                                     I_CLK,
    input  logic                                     I_ASYN_RSTN,
    input  logic                                     start,
    // Buffer read
    output logic [sa_pkg::idx_w-1:0]                 x_rd_row,
    output logic [sa_pkg::idx_w-1:0]                 w_rd_col,
    input  logic [sa_pkg::sa_dim*sa_pkg::data_w-1:0] x_rd_data,
    input  logic [sa_pkg::sa_dim*sa_pkg::data_w-1:0] w_rd_data,
    // Array side
    output logic [sa_pkg::sa_dim*sa_pkg::data_w-1:0] x_lane,
    output logic [sa_pkg::sa_dim*sa_pkg::data_w-1:0] w_lane,
    output logic                                     shift_en,
    output logic                                     acc_clr,
    output logic                                     busy,
    output logic                                     done
);
    import sa_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_feed,
        s_drain
    } state_t;

    state_t            state;
    logic [step_w-1:0] step;
    logic              lane_live;

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state <= s_idle;
            step  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_feed;
                        step  <= '0;
                    end
                end
                s_feed: begin
                    if (step == step_w'(feed_cycles - 1)) begin
                        state <= s_drain;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                s_drain: begin
                    state <= s_idle;   // Last PE has taken its final product
                    done  <= 1'b1;
                end
                default: state <= s_idle;
            endcase
        end
    end

    assign shift_en  = (state == s_feed);
    assign busy      = (state != s_idle);
    assign acc_clr   = start;
    assign lane_live = shift_en && (step < sa_dim);  // Zeros past the inner dim

    assign x_rd_row = step[idx_w-1:0];
    assign w_rd_col = step[idx_w-1:0];

    //////////////////////////////////////////////////////////////////////
    // Skew lines, lane i lags by i shifts
    //////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < sa_dim; i++) begin : g_lane
        logic [data_w-1:0] x_raw;
        logic [data_w-1:0] w_raw;

        assign x_raw = lane_live ? x_rd_data[i*data_w +: data_w] : '0;
        assign w_raw = lane_live ? w_rd_data[i*data_w +: data_w] : '0;

        if (i == 0) begin : g_direct
            assign x_lane[i*data_w +: data_w] = x_raw;
            assign w_lane[i*data_w +: data_w] = w_raw;
        end else begin : g_delay
            logic [data_w-1:0] x_dly [i];
            logic [data_w-1:0] w_dly [i];

            always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
                if (!I_ASYN_RSTN) begin
                    for (int m = 0; m < i; m++) begin
                        x_dly[m] <= '0;
                        w_dly[m] <= '0;
                    end
                end else if (shift_en) begin
                    x_dly[0] <= x_raw;
                    w_dly[0] <= w_raw;
                    for (int m = 1; m < i; m++) begin
                        x_dly[m] <= x_dly[m-1];
                        w_dly[m] <= w_dly[m-1];
                    end
                end
            end

            assign x_lane[i*data_w +: data_w] = x_dly[i-1];
            assign w_lane[i*data_w +: data_w] = w_dly[i-1];
        end
    end

endmodule

`default_nettype wire

/* design/sa_pe.sv */
`default_nettype none

module sa_pe (
    input  logic                             I_CLK,
    input  logic                             I_ASYN_RSTN,
    input  logic                             shift_en,
    input  logic                             acc_clr,
    input  logic signed [sa_pkg::data_w-1:0] x_in,   // From the left
    input  logic signed [sa_pkg::data_w-1:0] w_in,   // From above
    output logic signed [sa_pkg::data_w-1:0] x_out,
    output logic signed [sa_pkg::data_w-1:0] w_out,
    output logic signed [sa_pkg::acc_w-1:0]  acc
);
    import sa_pkg::*;

    logic signed [2*data_w-1:0] prod;
    logic signed [acc_w-1:0]    scaled;

    // Full Q4.26 product, back to Q2.13 by an arithmetic shift
    assign prod   = x_in * w_in;
    assign scaled = acc_w'(prod >>> frac_w);

    // Operand pass-through registers
    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            x_out <= '0;
            w_out <= '0;
        end else if (shift_en) begin
            x_out <= x_in;
            w_out <= w_in;
        end
    end

    // Output stationary sum
    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            acc <= '0;
        end else if (acc_clr) begin
            acc <= '0;
        end else if (shift_en) begin
            acc <= acc + scaled;  // Wraps, saturation happens on readout
        end
    end

endmodule

`default_nettype wire

/* design/sa_array.sv */
`default_nettype none

module sa_array (
    input  logic                                     I_CLK,
    input  logic                                     I_ASYN_RSTN,
    input  logic                                     shift_en,
    input  logic                                     acc_clr,
    input  logic [sa_pkg::sa_dim*sa_pkg::data_w-1:0] x_lane,
    input  logic [sa_pkg::sa_dim*sa_pkg::data_w-1:0] w_lane,
    output logic [sa_pkg::elem_n*sa_pkg::data_w-1:0] result_bus
);
    import sa_pkg::*;

    // Column sa_dim and row sa_dim hold what leaves the far edges
    logic signed [data_w-1:0] x_h [sa_dim][sa_dim+1];
    logic signed [data_w-1:0] w_v [sa_dim+1][sa_dim];
    logic signed [acc_w-1:0]  acc [sa_dim][sa_dim];

    for (genvar k = 0; k < sa_dim; k++) begin : g_edge
        assign x_h[k][0] = x_lane[k*data_w +: data_w];
        assign w_v[0][k] = w_lane[k*data_w +: data_w];
    end

    //////////////////////////////////////////////////////////////////////
    // PE grid, x moves right and w moves down
    //////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < sa_dim; i++) begin : g_row
        for (genvar j = 0; j < sa_dim; j++) begin : g_col
            logic [data_w-1:0] sat;

            sa_pe u_pe (
                .I_CLK       (I_CLK),
                .I_ASYN_RSTN (I_ASYN_RSTN),
                .shift_en    (shift_en),
                .acc_clr     (acc_clr),
                .x_in        (x_h[i][j]),
                .w_in        (w_v[i][j]),
                .x_out       (x_h[i][j+1]),
                .w_out       (w_v[i+1][j]),
                .acc         (acc[i][j])
            );

            // Clamp to the Q2.13 range
            always_comb begin
                if (acc[i][j] > sat_max) begin
                    sat = data_w'(sat_max);
                end else if (acc[i][j] < sat_min) begin
                    sat = data_w'(sat_min);
                end else begin
                    sat = acc[i][j][data_w-1:0];
                end
            end

            assign result_bus[(i*sa_dim + j)*data_w +: data_w] = sat;  // Row-major
        end
    end

endmodule

`default_nettype wire

/* design/sa_top.sv */
`default_nettype none

module sa_top (
    input  logic                       I_CLK,
    input  logic                       I_ASYN_RSTN,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [sa_pkg::addr_w-1:0]  paddr,
    input  logic [sa_pkg::pdata_w-1:0] pwdata,
    output logic [sa_pkg::pdata_w-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);
    import sa_pkg::*;

    logic                       start;
    logic                       busy;
    logic                       done;
    logic                       shift_en;
    logic                       acc_clr;
    logic [idx_w-1:0]           x_rd_row;
    logic [idx_w-1:0]           w_rd_col;
    logic [sa_dim*data_w-1:0]   x_rd_data;
    logic [sa_dim*data_w-1:0]   w_rd_data;
    logic [sa_dim*data_w-1:0]   x_lane;
    logic [sa_dim*data_w-1:0]   w_lane;
    logic [elem_n*data_w-1:0]   result_bus;

    //////////////////////////////////////////////////////////////////////
    // Register file, feeder and array
    //////////////////////////////////////////////////////////////////////
    sa_apb_regs u_regs (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .busy        (busy),
        .done        (done),
        .result_bus  (result_bus),
        .start       (start),
        .x_rd_row    (x_rd_row),
        .w_rd_col    (w_rd_col),
        .x_rd_data   (x_rd_data),
        .w_rd_data   (w_rd_data)
    );

    sa_operand_feeder u_feeder (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .start       (start),
        .x_rd_row    (x_rd_row),
        .w_rd_col    (w_rd_col),
        .x_rd_data   (x_rd_data),
        .w_rd_data   (w_rd_data),
        .x_lane      (x_lane),
        .w_lane      (w_lane),
        .shift_en    (shift_en),
        .acc_clr     (acc_clr),
        .busy        (busy),
        .done        (done)
    );

    sa_array u_array (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .shift_en    (shift_en),
        .acc_clr     (acc_clr),
        .x_lane      (x_lane),
        .w_lane      (w_lane),
        .result_bus  (result_bus)
    );

endmodule

`default_nettype wire

/* test/sa_clk_gen.sv */
`default_nettype none

module sa_clk_gen (
    output logic I_CLK,
    output logic I_ASYN_RSTN
);
    localparam int half_period  = 10;  // 20 per cycle
    localparam int reset_cycles = 16;

    initial begin
        I_CLK = 1'b0;
        forever #(half_period) I_CLK = ~I_CLK;
    end

    // Release on a rising edge
    initial begin
        I_ASYN_RSTN = 1'b0;
        repeat (reset_cycles) @(posedge I_CLK);
        I_ASYN_RSTN <= 1'b1;
    end

endmodule

`default_nettype wire

/* test/sa_properties.sv */
`default_nettype none

module sa_properties (
    input logic I_CLK,
    input logic I_ASYN_RSTN,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic busy
);
    import sa_pkg::*;

    logic [7:0] busy_len;  // Busy cycles seen before this edge

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            busy_len <= '0;
        end else if (busy) begin
            busy_len <= busy_len + 1'b1;
        end else begin
            busy_len <= '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // APB and run timing
    //////////////////////////////////////////////////////////////////////
    a_err_in_access: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        pslverr |-> (psel && penable))
        else $error("pslverr high outside an APB access phase");

    a_ready_high: assert property (@(posedge I_CLK) pready)
        else $error("pready went low");

    // Feed plus one drain cycle
    a_busy_bound: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        busy |-> (busy_len < 8'(feed_cycles + 1)))
        else $error("busy held longer than the feed and drain cycles");

endmodule

`default_nettype wire

/* test/sa_tb.sv */
`default_nettype none

module sa_tb;
    import sa_pkg::*;

    localparam int run_count      = 12;    // Array runs over all tests
    localparam int cycles_per_run = 1000;  // Load, poll and readback of one run
    localparam int max_polls      = 50;

    logic               I_CLK;
    logic               I_ASYN_RSTN;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [addr_w-1:0]  paddr;
    logic [pdata_w-1:0] pwdata;
    logic [pdata_w-1:0] prdata;
    logic               pready;
    logic               pslverr;

    logic [data_w-1:0]  x_mat [elem_n];  // Host copies, row-major
    logic [data_w-1:0]  w_mat [elem_n];
    logic [31:0]        lfsr_state;

    // Pending compares
    string              chk_name [$];
    logic [pdata_w-1:0] chk_got  [$];
    logic [pdata_w-1:0] chk_exp  [$];

    int checks       = 0;
    int errors       = 0;
    int test_errors  = 0;
    int tests        = 0;
    int tests_failed = 0;

    sa_clk_gen u_clk_gen (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN)
    );

    sa_top u_dut (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    bind sa_top sa_properties u_props (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .psel        (psel),
        .penable     (penable),
        .pready      (pready),
        .pslverr     (pslverr),
        .busy        (busy)
    );

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    //////////////////////////////////////////////////////////////////////
    // Galois form, taps on the right shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] widen(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [addr_w-1:0] elem_addr(input logic [addr_w-1:0] base, input int e);
        return base + addr_w'(4 * e);
    endfunction

    // Expected read word of one result element
    function automatic logic [pdata_w-1:0] ref_matmul(input int row, input int col);
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic signed [31:0] sum;
        logic [15:0]        res;
        sum = 0;
        for (int k = 0; k < sa_dim; k++) begin
            a   = widen(x_mat[row*sa_dim + k]);
            b   = widen(w_mat[k*sa_dim + col]);
            sum = sum + ((a * b) >>> frac_w);  // Q4.26 back to Q2.13
        end
        if (sum > 32'sd32767) begin
            res = 16'h7FFF;
        end else if (sum < -32'sd32768) begin
            res = 16'h8000;
        end else begin
            res = sum[15:0];
        end
        return widen(res);
    endfunction

    task automatic apb_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge I_CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge I_CLK);
        penable <= 1'b1;
        @(negedge I_CLK);
        err = pslverr;
        queue_check("pready", {31'b0, pready}, 32'h1);
        @(posedge I_CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [addr_w-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge I_CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge I_CLK);
        penable <= 1'b1;
        @(negedge I_CLK);  // Access phase, prdata settled
        data = prdata;
        err  = pslverr;
        queue_check("pready", {31'b0, pready}, 32'h1);
        @(posedge I_CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic queue_check(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_name.push_back(name);
        chk_got.push_back(got);
        chk_exp.push_back(exp);
    endtask

    task automatic write_expect(input logic [addr_w-1:0] addr, input logic [31:0] data,
                                input logic exp_err);
        logic err;
        apb_write(addr, data, err);
        queue_check("pslverr", {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic read_expect(input logic [addr_w-1:0] addr, input string name,
                               input logic [31:0] exp, input logic exp_err);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        queue_check("pslverr", {31'b0, err}, {31'b0, exp_err});
        if (!exp_err) begin
            queue_check(name, data, exp);
        end
    endtask

    task automatic load_operands();
        for (int e = 0; e < elem_n; e++) begin
            write_expect(elem_addr(win_x, e), {16'h0, x_mat[e]}, 1'b0);
            write_expect(elem_addr(win_w, e), {16'h0, w_mat[e]}, 1'b0);
        end
    endtask

    task automatic wait_done();
        logic [31:0] status;
        logic        err;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < max_polls) begin
            apb_read(reg_status, status, err);
            queue_check("pslverr", {31'b0, err}, 32'h0);
            polls++;
        end
        assert (status[1]) else begin
            $display("Run never reported done after %0d status polls", polls);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_results();
        for (int e = 0; e < elem_n; e++) begin
            read_expect(elem_addr(win_out, e), $sformatf("prdata out[%0d]", e),
                        ref_matmul(e / sa_dim, e % sa_dim), 1'b0);
        end
    endtask

    // Values within plus or minus one half
    task automatic fill_small();
        logic [12:0] v;
        for (int e = 0; e < elem_n; e++) begin
            v        = 13'(rand_bits(13));
            x_mat[e] = {{3{v[12]}}, v};
            v        = 13'(rand_bits(13));
            w_mat[e] = {{3{v[12]}}, v};
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge I_CLK);
        @(negedge I_CLK);  // Compare queue drained
        tests++;
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests, name, test_errors);
        end
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare process
    //////////////////////////////////////////////////////////////////////
    always @(posedge I_CLK) begin
        string       name;
        logic [31:0] got;
        logic [31:0] exp;
        while (chk_got.size() > 0) begin
            name = chk_name.pop_front();
            got  = chk_got.pop_front();
            exp  = chk_exp.pop_front();
            checks++;
            assert (got === exp) else begin
                $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
                errors++;
                test_errors++;
            end
        end
    end

    // Watchdog
    initial begin
        repeat ((run_count + 2) * cycles_per_run) @(posedge I_CLK);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////
    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 32'he780;
        wait (I_ASYN_RSTN === 1'b1);
        @(posedge I_CLK);

        read_expect(reg_status, "prdata status", 32'h0, 1'b0);
        write_expect(elem_addr(win_x, 5), 32'h1234_9ABC, 1'b0);  // Upper half ignored
        read_expect(elem_addr(win_x, 5), "prdata x[5]", 32'hFFFF_9ABC, 1'b0);
        finish_test("reset and readback");

        for (int e = 0; e < elem_n; e++) begin
            x_mat[e] = 16'(rand_bits(16));
            w_mat[e] = (e % (sa_dim + 1) == 0) ? 16'h2000 : 16'h0000;  // 1.0 on diagonal
        end
        load_operands();
        write_expect(reg_ctrl, 32'h1, 1'b0);
        wait_done();
        for (int e = 0; e < elem_n; e++) begin
            read_expect(elem_addr(win_out, e), $sformatf("prdata out[%0d]", e),
                        widen(x_mat[e]), 1'b0);
        end
        finish_test("identity weights");

        for (int r = 0; r < 8; r++) begin
            fill_small();
            load_operands();
            write_expect(reg_ctrl, 32'h1, 1'b0);
            wait_done();
            check_results();
        end
        finish_test("random runs");

        // Positive and negative full scale
        for (int e = 0; e < elem_n; e++) begin
            x_mat[e] = 16'h7FFF;
            w_mat[e] = 16'h7FFF;
        end
        load_operands();
        write_expect(reg_ctrl, 32'h1, 1'b0);
        wait_done();
        check_results();
        read_expect(win_out, "prdata out[0]", 32'h0000_7FFF, 1'b0);
        for (int e = 0; e < elem_n; e++) begin
            x_mat[e] = 16'h8000;
        end
        load_operands();
        write_expect(reg_ctrl, 32'h1, 1'b0);
        wait_done();
        check_results();
        read_expect(win_out, "prdata out[0]", 32'hFFFF_8000, 1'b0);
        finish_test("saturation");

        fill_small();
        load_operands();
        write_expect(reg_ctrl, 32'h1, 1'b0);
        read_expect(reg_status, "prdata status", 32'h1, 1'b0);
        write_expect(elem_addr(win_x, 3), 32'h0000_1111, 1'b1);
        write_expect(elem_addr(win_w, 9), 32'h0000_2222, 1'b1);
        write_expect(reg_ctrl, 32'h1, 1'b1);
        wait_done();
        for (int e = 0; e < elem_n; e++) begin
            read_expect(elem_addr(win_x, e), $sformatf("prdata x[%0d]", e),
                        widen(x_mat[e]), 1'b0);
            read_expect(elem_addr(win_w, e), $sformatf("prdata w[%0d]", e),
                        widen(w_mat[e]), 1'b0);
        end
        check_results();
        finish_test("writes while busy");

        read_expect(8'h10, "prdata unmapped", 32'h0, 1'b1);
        write_expect(8'h3C, 32'h1, 1'b1);
        write_expect(elem_addr(win_out, 2), 32'h1, 1'b1);
        check_results();
        read_expect(reg_status, "prdata status", 32'h2, 1'b0);  // Done stays sticky
        finish_test("error responses");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/sa_pkg.sv
design/sa_apb_regs.sv
design/sa_operand_feeder.sv
design/sa_pe.sv
design/sa_array.sv
design/sa_top.sv
test/sa_clk_gen.sv
test/sa_properties.sv
test/sa_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := sa_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
PASS_MSG   := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
